/* design/fetch_pkg.sv */
// fetch stage shared definitions
// address, instruction and line types, the fixed cache geometry and the
// structs passed between fetch control, cache store and refill port
package fetch_pkg;

    // basic widths
    localparam int ADDR_W     = 64;
    localparam int INSTR_W    = 32;
    localparam int LINE_W     = 128;
    localparam int INDEX_W    = 4;
    localparam int WORD_SEL_W = 2;

    // field positions inside a byte address
    localparam int WORD_LSB  = 2;
    localparam int INDEX_LSB = 4;
    localparam int TAG_LSB   = 8;
    localparam int TAG_W     = ADDR_W - TAG_LSB;

    // direct mapped, one line per index
    localparam int LINE_COUNT = 16;

    localparam logic [ADDR_W-1:0] RESET_PC = 64'h8000_0000;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    // four instructions, word 0 in the low bits
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    typedef struct packed {
        logic   hit;
        instr_t instr;
    } lookup_rsp_t;

    // line_addr always has the low four bits cleared
    typedef struct packed {
        logic  start;
        addr_t line_addr;
    } refill_req_t;

    typedef struct packed {
        logic  done;
        addr_t line_addr;
        line_t line;
    } refill_rsp_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_out_t;

    typedef enum logic [1:0] {S_START, S_LOOKUP, S_REFILL, S_HOLD} fetch_state_t;

endpackage

/* design/fetch_ctrl.sv */
`timescale 1ns/10ps
// fetch control
// owns the program counter and the fetch FSM, runs the cache lookup,
// asks the refill port for a line on a miss and holds the instruction
// until the decode side takes it
module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // decode side
    input  logic        take,
    input  addr_t       next_pc,
    input  logic        flush,
    // cache store and refill port
    input  lookup_rsp_t lookup,
    input  refill_rsp_t refill_rsp,
    output addr_t       pc,
    output refill_req_t refill_req,
    // status and result
    output logic        instr_valid,
    output logic        busy,
    output fetch_out_t  fetch,
    output logic        cache_flush
);

    fetch_state_t state_q;
    fetch_state_t state_d;
    addr_t        pc_q;
    instr_t       instr_q;
    logic         flush_q;
    logic         hit_now;
    logic         miss_now;
    logic         take_now;

    // lookup result only counts in S_LOOKUP
    assign hit_now  = (state_q == S_LOOKUP) && lookup.hit;
    assign miss_now = (state_q == S_LOOKUP) && !lookup.hit;
    // take is ignored unless an instruction is held
    assign take_now = (state_q == S_HOLD) && take;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_START: begin
                // first lookup of the reset pc
                state_d = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (lookup.hit) begin
                    state_d = S_HOLD;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                // line is written on done, so the next lookup hits
                if (refill_rsp.done) begin
                    state_d = S_LOOKUP;
                end
            end
            S_HOLD: begin
                if (take) begin
                    state_d = S_LOOKUP;
                end
            end
            default: begin
                state_d = S_START;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_START;
        end else begin
            state_q <= state_d;
        end
    end

    // program counter, redirect or sequential pc comes from decode
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (take_now) begin
            pc_q <= next_pc;
        end
    end

    // held instruction
    always_ff @(posedge clk) begin
        if (hit_now) begin
            instr_q <= lookup.instr;
        end
    end

    // fence.i invalidate, one cycle late toward the cache
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush;
        end
    end

    assign pc          = pc_q;
    assign cache_flush = flush_q;

    // one cycle start pulse, state leaves S_LOOKUP on the same edge
    always_comb begin
        refill_req.start     = miss_now;
        refill_req.line_addr = {pc_q[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    end

    // S_START counts as neither busy nor valid
    assign instr_valid = (state_q == S_HOLD);
    assign busy        = (state_q == S_LOOKUP) || (state_q == S_REFILL);

    always_comb begin
        fetch.pc    = pc_q;
        fetch.instr = instr_q;
    end

endmodule

/* design/icache_store.sv */
`timescale 1ns/10ps
// instruction cache store
// direct mapped tag, valid and line arrays with a combinational lookup,
// line write on refill completion and whole-cache invalidate
module icache_store
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // lookup address from fetch control
    input  addr_t       pc,
    // completed refill from the refill port
    input  refill_rsp_t refill_rsp,
    input  logic        cache_flush,
    output lookup_rsp_t lookup
);

    // per line state
    logic [LINE_COUNT-1:0] valid_q;
    tag_t                  tag_mem  [LINE_COUNT];
    line_t                 line_mem [LINE_COUNT];

    // lookup side fields
    index_t    rd_index;
    tag_t      rd_tag;
    word_sel_t rd_word;
    line_t     rd_line;
    logic      tag_match;

    // refill side fields
    index_t    wr_index;
    tag_t      wr_tag;

    assign rd_index = pc[INDEX_LSB +: INDEX_W];
    assign rd_tag   = pc[TAG_LSB +: TAG_W];
    assign rd_word  = pc[WORD_LSB +: WORD_SEL_W];

    assign wr_index = refill_rsp.line_addr[INDEX_LSB +: INDEX_W];
    assign wr_tag   = refill_rsp.line_addr[TAG_LSB +: TAG_W];

    // read port
    assign rd_line   = line_mem[rd_index];
    assign tag_match = (tag_mem[rd_index] == rd_tag);

    always_comb begin
        // a pending invalidate forces a miss so a lookup in the same
        // cycle cannot return a stale line
        lookup.hit   = valid_q[rd_index] && tag_match && !cache_flush;
        // word 0 sits in the low 32 bits
        lookup.instr = rd_line[rd_word*INSTR_W +: INSTR_W];
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (rst || cache_flush) begin
            valid_q <= '0;
        end else if (refill_rsp.done) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // tag and data arrays, written only on a finished refill
    always_ff @(posedge clk) begin
        if (refill_rsp.done) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= refill_rsp.line;
        end
    end

endmodule

/* design/refill_port.sv */
`timescale 1ns/10ps
// refill port
// four-phase req/ack master toward memory, fetches one aligned line per
// request and reports done only once ack has been released
module refill_port
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // fetch control side
    input  refill_req_t refill_req,
    output refill_rsp_t refill_rsp,
    // memory side
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ack,
    input  line_t       mem_rdata
);

    // handshake phases
    typedef enum logic [1:0] {
        P_IDLE,
        P_REQUEST,
        P_RELEASE,
        P_DONE
    } phase_t;

    phase_t phase_q;
    phase_t phase_d;
    addr_t  addr_q;
    line_t  line_q;
    logic   capture;

    // rdata is valid while ack is high, take it on the first ack cycle
    assign capture = (phase_q == P_REQUEST) && mem_ack;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            P_IDLE: begin
                if (refill_req.start) begin
                    phase_d = P_REQUEST;
                end
            end
            P_REQUEST: begin
                if (mem_ack) begin
                    phase_d = P_RELEASE;
                end
            end
            P_RELEASE: begin
                // req already low, wait for memory to drop ack
                if (!mem_ack) begin
                    phase_d = P_DONE;
                end
            end
            P_DONE: begin
                phase_d = P_IDLE;
            end
            default: begin
                phase_d = P_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= P_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // address held for the whole transfer
    always_ff @(posedge clk) begin
        if ((phase_q == P_IDLE) && refill_req.start) begin
            addr_q <= refill_req.line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            line_q <= mem_rdata;
        end
    end

    assign mem_req  = (phase_q == P_REQUEST);
    assign mem_addr = addr_q;

    // done is a single cycle pulse
    always_comb begin
        refill_rsp.done      = (phase_q == P_DONE);
        refill_rsp.line_addr = addr_q;
        refill_rsp.line      = line_q;
    end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/10ps
// instruction fetch stage top
// connects fetch control to the cache store and the memory refill port
module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // decode side
    input  logic       take,
    input  addr_t      next_pc,
    input  logic       flush,
    output logic       instr_valid,
    output logic       busy,
    output fetch_out_t fetch,
    // memory side
    output logic       mem_req,
    output addr_t      mem_addr,
    input  logic       mem_ack,
    input  line_t      mem_rdata
);

    addr_t       pc;
    lookup_rsp_t lookup;
    refill_req_t refill_req;
    refill_rsp_t refill_rsp;
    logic        cache_flush;

    fetch_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .take        (take),
        .next_pc     (next_pc),
        .flush       (flush),
        .lookup      (lookup),
        .refill_rsp  (refill_rsp),
        .pc          (pc),
        .refill_req  (refill_req),
        .instr_valid (instr_valid),
        .busy        (busy),
        .fetch       (fetch),
        .cache_flush (cache_flush)
    );

    icache_store u_store (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .refill_rsp  (refill_rsp),
        .cache_flush (cache_flush),
        .lookup      (lookup)
    );

    // one outstanding line refill at a time
    refill_port u_refill (
        .clk        (clk),
        .rst        (rst),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

endmodule

/* verification/mem_responder.sv */
`timescale 1ns/10ps
// testbench memory for the refill port
// answers four-phase requests after a programmable delay and reports
// handshake order violations in plain words
module mem_responder
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_req,
    input  addr_t      mem_addr,
    output logic       mem_ack,
    output line_t      mem_rdata,
    // line content for mem_addr, supplied by the testbench
    input  line_t      line_data,
    input  logic [2:0] ack_delay,
    input  logic [1:0] release_delay,
    output int         protocol_errors
);

    typedef enum logic [1:0] {R_IDLE, R_WAIT, R_ACK, R_DROP} resp_state_t;

    resp_state_t state_q   = R_IDLE;
    logic [2:0]  cnt_q     = 3'd0;
    logic        ack_q     = 1'b0;
    line_t       data_q    = '0;
    logic        req_prev  = 1'b0;
    addr_t       addr_prev = '0;
    int          err_q     = 0;

    assign mem_ack         = ack_q;
    assign mem_rdata       = data_q;
    assign protocol_errors = err_q;

    always @(posedge clk) begin
        if (rst) begin
            state_q <= R_IDLE;
            ack_q   <= 1'b0;
            cnt_q   <= 3'd0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    if (mem_req) begin
                        cnt_q   <= ack_delay;
                        state_q <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    // data is valid for as long as ack stays high
                    if (cnt_q == 3'd0) begin
                        ack_q   <= 1'b1;
                        data_q  <= line_data;
                        state_q <= R_ACK;
                    end else begin
                        cnt_q <= cnt_q - 3'd1;
                    end
                end
                R_ACK: begin
                    if (!mem_req) begin
                        cnt_q   <= {1'b0, release_delay};
                        state_q <= R_DROP;
                    end
                end
                default: begin
                    if (cnt_q == 3'd0) begin
                        ack_q   <= 1'b0;
                        state_q <= R_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 3'd1;
                    end
                end
            endcase
        end
    end

    // handshake order checker
    always @(posedge clk) begin : proto_check
        int n;
        n = 0;
        if (!rst) begin
            if (mem_req && req_prev && (mem_addr != addr_prev)) begin
                $display("memory protocol error: mem_addr changed while mem_req was high");
                n++;
            end
            if (!mem_req && req_prev && !ack_q) begin
                $display("memory protocol error: mem_req dropped before mem_ack rose");
                n++;
            end
            if (mem_req && !req_prev && ack_q) begin
                $display("memory protocol error: mem_req rose while mem_ack was still high");
                n++;
            end
        end
        err_q     <= err_q + n;
        req_prev  <= mem_req;
        addr_prev <= mem_addr;
    end

endmodule

/* verification/fetch_tb.sv */
`timescale 1ns/10ps
// fetch stage testbench
// LFSR driven fetch sequences against a direct mapped cache model,
// with a delayed four-phase memory behind the refill port
module fetch_tb
    import fetch_pkg::*;
;

    localparam int   RESET_CYCLES = 4;
    localparam int   WAIT_LIMIT   = 200;
    localparam int   HIT_EDGES    = 2;
    localparam addr_t WINDOW_BASE = RESET_PC;

    logic       clk;
    logic       rst;
    logic       take;
    addr_t      next_pc;
    logic       flush;
    logic       instr_valid;
    logic       busy;
    fetch_out_t fetch;
    logic       mem_req;
    addr_t      mem_addr;
    logic       mem_ack;
    line_t      mem_rdata;
    line_t      line_data;
    logic [2:0] ack_delay;
    logic [1:0] release_delay;
    int         protocol_errors;

    // memory generation, bumped to model self-modifying code
    logic [7:0]  gen_q = 8'd0;
    logic [31:0] lfsr_q = 32'h25dc_354e;
    int          errors = 0;
    int          checks = 0;
    int          refill_count = 0;
    logic        req_seen = 1'b0;
    logic        timed_out = 1'b0;
    addr_t       cur_pc;
    // pc of the fetch in flight, its line is the one to be requested
    addr_t       pend_pc = RESET_PC;
    int          model_misses = 0;

    // cache model, one entry per index
    logic       m_valid [LINE_COUNT];
    tag_t       m_tag   [LINE_COUNT];
    logic [7:0] m_gen   [LINE_COUNT];

    fetch_top DUT (
        .clk(clk), .rst(rst), .take(take), .next_pc(next_pc), .flush(flush),
        .instr_valid(instr_valid), .busy(busy), .fetch(fetch),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    mem_responder u_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata), .line_data(line_data),
        .ack_delay(ack_delay), .release_delay(release_delay),
        .protocol_errors(protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory word, a function of the whole address and the generation
    function automatic instr_t mem_word(input addr_t a, input logic [7:0] g);
        logic [31:0] h;
        h = a[31:0] ^ a[63:32] ^ ({24'd0, g} * 32'h9e37_79b9);
        return (h * 32'h0100_0193) ^ 32'h0000_0013;
    endfunction

    // word 0 in the low bits
    function automatic line_t mem_line(input addr_t a, input logic [7:0] g);
        return {mem_word(a + 64'd12, g), mem_word(a + 64'd8, g),
                mem_word(a + 64'd4, g), mem_word(a, g)};
    endfunction

    assign line_data = mem_line({mem_addr[63:4], 4'h0}, gen_q);

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // count refills by mem_req rises and check the requested line
    always @(posedge clk) begin
        req_seen <= mem_req;
        if (mem_req && !req_seen) begin
            refill_count <= refill_count + 1;
            check_pc("mem_addr", mem_addr, {pend_pc[63:4], 4'h0});
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic model_flush();
        for (int i = 0; i < LINE_COUNT; i++) begin
            m_valid[i] = 1'b0;
        end
    endtask

    // predict hit or miss and the word, then fill on a miss
    task automatic model_fetch(input addr_t a, output logic hit, output instr_t exp);
        index_t idx;
        idx = a[INDEX_LSB +: INDEX_W];
        hit = m_valid[idx] && (m_tag[idx] == a[TAG_LSB +: TAG_W]);
        if (!hit) begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = a[TAG_LSB +: TAG_W];
            m_gen[idx]   = gen_q;
            model_misses++;
        end
        exp = mem_word(a, m_gen[idx]);
    endtask

    // one cycle take pulse, the DUT samples it at the second edge
    task automatic take_next(input addr_t nxt, input logic [2:0] ad, input logic [1:0] rd);
        @(posedge clk);
        take          <= 1'b1;
        next_pc       <= nxt;
        ack_delay     <= ad;
        release_delay <= rd;
        @(posedge clk);
        take <= 1'b0;
    endtask

    // edges counts the edges after the take edge
    task automatic wait_valid(input addr_t a, output int edges, output logic ok);
        edges = 0;
        ok    = 1'b0;
        while (!ok && edges < WAIT_LIMIT) begin
            @(negedge clk);
            if (instr_valid) begin
                ok = 1'b1;
            end else begin
                if (!busy) begin
                    report_error($sformatf("busy low while instr_valid low at pc %h", a));
                end
                @(posedge clk);
                edges++;
            end
        end
        if (!ok) begin
            timed_out = 1'b1;
            report_error($sformatf("timeout waiting for instr_valid at pc %h", a));
        end
    endtask

    task automatic run_fetch(input addr_t nxt);
        logic        hit;
        instr_t      exp;
        logic [31:0] r;
        logic [2:0]  ad;
        int          edges;
        logic        ok;
        model_fetch(nxt, hit, exp);
        r  = rand_bits(3);
        ad = r[2:0];
        r  = rand_bits(2);
        pend_pc = nxt;
        take_next(nxt, ad, r[1:0]);
        wait_valid(nxt, edges, ok);
        if (ok) begin
            check_pc("fetch.pc", fetch.pc, nxt);
            check_instr("fetch.instr", fetch.instr, exp);
            if (hit) begin
                if (edges + 1 != HIT_EDGES) begin
                    report_error($sformatf("hit at pc %h became valid %0d edges after take",
                                           nxt, edges + 1));
                end
            end
            cur_pc = nxt;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        $display("%-12s %s", name, (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        int          e0;
        int          rc0;
        int          mm0;
        int          new_lines;
        int          edges;
        logic        ok;
        logic [31:0] r;
        addr_t       nxt;
        instr_t      exp;

        rst           = 1'b1;
        take          = 1'b0;
        next_pc       = '0;
        flush         = 1'b0;
        ack_delay     = 3'd1;
        release_delay = 2'd0;
        model_flush();

        // reset, then the first refill of RESET_PC
        e0 = errors;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            if (instr_valid || busy || mem_req) begin
                report_error("instr_valid, busy or mem_req high during reset");
            end
        end
        model_fetch(RESET_PC, ok, exp);
        wait_valid(RESET_PC, edges, ok);
        if (ok) begin
            check_pc("fetch.pc", fetch.pc, RESET_PC);
            check_instr("fetch.instr", fetch.instr, exp);
            check_count("refill count", refill_count, 1);
        end
        cur_pc = RESET_PC;
        finish_test("reset", e0);

        // sequential fetch across lines, one refill per new line
        if (!timed_out) begin
            e0        = errors;
            rc0       = refill_count;
            new_lines = 0;
            for (int i = 0; i < 12 && !timed_out; i++) begin
                nxt = cur_pc + 64'd4;
                if (nxt[3:0] == 4'd0) begin
                    new_lines++;
                end
                run_fetch(nxt);
            end
            check_count("refill count", refill_count - rc0, new_lines);
            finish_test("sequential", e0);
        end

        // every word of the current line must hit in two edges
        if (!timed_out) begin
            e0  = errors;
            rc0 = refill_count;
            for (logic [2:0] w = 3'd0; w < 3'd4; w++) begin
                run_fetch({cur_pc[63:4], w[1:0], 2'b00});
            end
            check_count("refill count", refill_count - rc0, 0);
            finish_test("hit_latency", e0);
        end

        // redirects inside a 4 KB window, mixed with sequential steps
        if (!timed_out) begin
            e0  = errors;
            rc0 = refill_count;
            mm0 = model_misses;
            for (int i = 0; i < 60 && !timed_out; i++) begin
                r = rand_bits(2);
                if (r[1:0] == 2'd0) begin
                    nxt = cur_pc + 64'd4;
                end else begin
                    r   = rand_bits(10);
                    nxt = {WINDOW_BASE[63:12], r[9:0], 2'b00};
                end
                run_fetch(nxt);
            end
            check_count("refill count", refill_count - rc0, model_misses - mm0);
            finish_test("redirect", e0);
        end

        // stale word before fence.i, new word after it
        if (!timed_out) begin
            e0  = errors;
            rc0 = refill_count;
            @(posedge clk);
            gen_q <= gen_q + 8'd1;
            run_fetch(cur_pc);
            check_count("refill count", refill_count - rc0, 0);
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            // cache_flush is one cycle late, valid bits clear on the next edge
            repeat (2) @(posedge clk);
            model_flush();
            run_fetch(cur_pc);
            check_count("refill count", refill_count - rc0, 1);
            finish_test("flush", e0);
        end

        // handshake violations seen by the memory over the whole run
        e0 = errors;
        if (protocol_errors != 0) begin
            report_error($sformatf("memory responder saw %0d protocol errors",
                                   protocol_errors));
        end
        finish_test("mem_protocol", e0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/icache_store.sv
design/refill_port.sv
design/fetch_top.sv
verification/mem_responder.sv
verification/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f build.f --top-module fetch_tb -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

# the log decides the result
if grep -q "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
